// File: common/rsPkg.sv
package rsPkg;

    // Tag and index widths
    localparam int PR_WIDTH   = 6;      // Physical register tag
    localparam int ROB_WIDTH  = 4;      // Reorder buffer index
    localparam int RS_NUM     = 4;      // Entries per station
    localparam int SLOT_WIDTH = 2;      // Bits to address one entry

    // Physical register tag, as renamed
    typedef logic [PR_WIDTH-1:0] physReg_t;

    // Reorder buffer slot of the micro-op
    typedef logic [ROB_WIDTH-1:0] robIdx_t;

    // Architectural register number, x0 to x31
    typedef logic [4:0] archReg_t;

    // Operation code handed over by decode
    typedef logic [3:0] aluOp_t;

    // Sign-extended immediate
    typedef logic [31:0] imm_t;

    // Entry index inside one station
    typedef logic [SLOT_WIDTH-1:0] slotIdx_t;

endpackage : rsPkg

// File: design/dispatchControl.sv
`timescale 1ns/100ps

module dispatchControl
import rsPkg::*;
(
    input  logic     addWe,         // Dispatch strobe, add station
    input  logic     mulWe,         // Dispatch strobe, mul station
    input  logic     addFull,       // No free add entry
    input  logic     mulFull,       // No free mul entry
    input  physReg_t prs1,          // Source tag 1 of the micro-op
    input  physReg_t prs2,          // Source tag 2 of the micro-op
    input  logic     prs1Ready,     // Register file ready bit, rs1
    input  logic     prs2Ready,     // Register file ready bit, rs2
    input  logic     cdbValid,
    input  physReg_t cdbPhysReg,
    input  archReg_t cdbArchReg,
    output logic     addWrite,      // Store into add station
    output logic     mulWrite,      // Store into mul station
    output logic     rs1ReadyIn,    // Ready bit as stored, rs1
    output logic     rs2ReadyIn     // Ready bit as stored, rs2
);

    logic cdbLive;      // Broadcast that may wake something
    logic bypass1;
    logic bypass2;

    // x0 results never wake an operand
    assign cdbLive = cdbValid && (cdbArchReg != '0);

    // Tag on the CDB right now, register file has not caught up yet
    assign bypass1 = cdbLive && (cdbPhysReg == prs1);
    assign bypass2 = cdbLive && (cdbPhysReg == prs2);

    assign rs1ReadyIn = prs1Ready || bypass1;
    assign rs2ReadyIn = prs2Ready || bypass2;

    // Station steering
    always_comb begin
        addWrite = 1'b0;
        mulWrite = 1'b0;
        if (addWe && !addFull) begin
            addWrite = 1'b1;            // Add has priority
        end else if (mulWe && !mulFull) begin
            mulWrite = 1'b1;
        end
        // Strobe into a full station is simply dropped
    end

endmodule : dispatchControl

// File: reservationStation/rsSlotPicker.sv
`timescale 1ns/100ps

module rsSlotPicker
import rsPkg::*;
(
    input  logic [RS_NUM-1:0] entryValid,   // Entry holds a micro-op
    input  logic [RS_NUM-1:0] entryReady1,  // Operand 1 available
    input  logic [RS_NUM-1:0] entryReady2,  // Operand 2 available
    output slotIdx_t          freeIdx,      // Write target
    output logic              full,         // No empty entry
    output slotIdx_t          issueIdx,     // Oldest-position ready entry
    output logic              issueFound    // issueIdx is meaningful
);

    logic [RS_NUM-1:0] candidate;

    // Valid and both sources ready
    assign candidate  = entryValid & entryReady1 & entryReady2;
    assign issueFound = |candidate;

    // Free slot search, last hit wins so the highest empty index is taken
    always_comb begin
        freeIdx = '0;
        full    = 1'b1;
        for (int i = 0; i < RS_NUM; i++) begin
            if (!entryValid[i]) begin
                freeIdx = slotIdx_t'(i);
                full    = 1'b0;
            end
        end
    end

    // Issue search runs downward
    always_comb begin
        issueIdx = '0;
        for (int i = RS_NUM - 1; i >= 0; i--) begin
            if (candidate[i]) begin
                issueIdx = slotIdx_t'(i);   // Lowest index survives
            end
        end
    end

endmodule : rsSlotPicker

// File: reservationStation/rsStation.sv
`timescale 1ns/100ps

module rsStation
import rsPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     flush,         // Branch mispredict, drop everything
    input  logic     write,         // Store the dispatched micro-op
    input  aluOp_t   op,
    input  physReg_t prs1,
    input  physReg_t prs2,
    input  physReg_t pDest,
    input  robIdx_t  robIdx,
    input  imm_t     imm,
    input  logic     rs1ReadyIn,    // Already bypassed
    input  logic     rs2ReadyIn,
    input  logic     cdbValid,
    input  physReg_t cdbPhysReg,
    input  archReg_t cdbArchReg,
    input  logic     fuReady,       // Unit takes a micro-op this cycle
    output logic     full,
    output logic     issueValid,
    output aluOp_t   issueOp,
    output physReg_t issuePrs1,
    output physReg_t issuePrs2,
    output physReg_t issuePDest,
    output robIdx_t  issueRob,
    output imm_t     issueImm
);

    // Control bits per entry
    logic [RS_NUM-1:0] entryValid;
    logic [RS_NUM-1:0] entryReady1;
    logic [RS_NUM-1:0] entryReady2;

    // Payload per entry
    aluOp_t   opQ    [RS_NUM];
    physReg_t prs1Q  [RS_NUM];
    physReg_t prs2Q  [RS_NUM];
    physReg_t pDestQ [RS_NUM];
    robIdx_t  robQ   [RS_NUM];
    imm_t     immQ   [RS_NUM];

    slotIdx_t freeIdx;
    slotIdx_t issueIdx;
    logic     issueFound;
    logic     issueNow;     // Candidate leaves at this edge
    logic     cdbLive;

    rsSlotPicker picker (
        .entryValid  (entryValid),
        .entryReady1 (entryReady1),
        .entryReady2 (entryReady2),
        .freeIdx     (freeIdx),
        .full        (full),
        .issueIdx    (issueIdx),
        .issueFound  (issueFound)
    );

    assign issueNow = fuReady && issueFound;
    assign cdbLive  = cdbValid && (cdbArchReg != '0);   // Ignore x0 writebacks

    // Valid and ready bits, issue strobe
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            entryValid  <= '0;
            entryReady1 <= '0;
            entryReady2 <= '0;
            issueValid  <= 1'b0;
        end else begin
            // Wakeup from the CDB
            for (int i = 0; i < RS_NUM; i++) begin
                if (entryValid[i] && cdbLive && (cdbPhysReg == prs1Q[i])) begin
                    entryReady1[i] <= 1'b1;
                end
                if (entryValid[i] && cdbLive && (cdbPhysReg == prs2Q[i])) begin
                    entryReady2[i] <= 1'b1;
                end
            end
            if (write) begin
                entryValid[freeIdx]  <= 1'b1;     // Free slot, never the issue slot
                entryReady1[freeIdx] <= rs1ReadyIn;
                entryReady2[freeIdx] <= rs2ReadyIn;
            end
            if (issueNow) begin
                entryValid[issueIdx] <= 1'b0;     // Reusable from the next edge
            end
            issueValid <= issueNow;               // One cycle per issued entry
        end
    end

    // Payload storage and issue registers
    always_ff @(posedge clk) begin
        if (write) begin
            opQ[freeIdx]    <= op;
            prs1Q[freeIdx]  <= prs1;
            prs2Q[freeIdx]  <= prs2;
            pDestQ[freeIdx] <= pDest;
            robQ[freeIdx]   <= robIdx;
            immQ[freeIdx]   <= imm;
        end
        if (issueNow) begin
            issueOp    <= opQ[issueIdx];
            issuePrs1  <= prs1Q[issueIdx];
            issuePrs2  <= prs2Q[issueIdx];
            issuePDest <= pDestQ[issueIdx];
            issueRob   <= robQ[issueIdx];
            issueImm   <= immQ[issueIdx];
        end
    end

endmodule : rsStation

// File: design/reserveTop.sv
`timescale 1ns/100ps

module reserveTop
import rsPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    // Dispatch side
    input  logic     addWe,
    input  logic     mulWe,
    input  aluOp_t   op,
    input  physReg_t prs1,
    input  physReg_t prs2,
    input  physReg_t pDest,
    input  robIdx_t  robIdx,
    input  imm_t     imm,
    input  logic     prs1Ready,
    input  logic     prs2Ready,
    // Common data bus
    input  logic     cdbValid,
    input  physReg_t cdbPhysReg,
    input  archReg_t cdbArchReg,
    input  logic     flush,
    // Functional units
    input  logic     addFuReady,
    input  logic     mulFuReady,
    output logic     addFull,
    output logic     mulFull,
    output logic     addIssueValid,
    output aluOp_t   addIssueOp,
    output physReg_t addIssuePrs1,
    output physReg_t addIssuePrs2,
    output physReg_t addIssuePDest,
    output robIdx_t  addIssueRob,
    output imm_t     addIssueImm,
    output logic     mulIssueValid,
    output aluOp_t   mulIssueOp,
    output physReg_t mulIssuePrs1,
    output physReg_t mulIssuePrs2,
    output physReg_t mulIssuePDest,
    output robIdx_t  mulIssueRob,
    output imm_t     mulIssueImm
);

    logic addWrite;
    logic mulWrite;
    logic rs1ReadyIn;   // Shared by both stations
    logic rs2ReadyIn;

    dispatchControl dispatch (
        .addWe      (addWe),
        .mulWe      (mulWe),
        .addFull    (addFull),
        .mulFull    (mulFull),
        .prs1       (prs1),
        .prs2       (prs2),
        .prs1Ready  (prs1Ready),
        .prs2Ready  (prs2Ready),
        .cdbValid   (cdbValid),
        .cdbPhysReg (cdbPhysReg),
        .cdbArchReg (cdbArchReg),
        .addWrite   (addWrite),
        .mulWrite   (mulWrite),
        .rs1ReadyIn (rs1ReadyIn),
        .rs2ReadyIn (rs2ReadyIn)
    );

    // Add unit station
    rsStation addStation (
        .clk (clk), .rst (rst), .flush (flush), .write (addWrite),
        .op (op), .prs1 (prs1), .prs2 (prs2), .pDest (pDest),
        .robIdx (robIdx), .imm (imm),
        .rs1ReadyIn (rs1ReadyIn), .rs2ReadyIn (rs2ReadyIn),
        .cdbValid (cdbValid), .cdbPhysReg (cdbPhysReg), .cdbArchReg (cdbArchReg),
        .fuReady (addFuReady), .full (addFull), .issueValid (addIssueValid),
        .issueOp (addIssueOp), .issuePrs1 (addIssuePrs1), .issuePrs2 (addIssuePrs2),
        .issuePDest (addIssuePDest), .issueRob (addIssueRob), .issueImm (addIssueImm)
    );

    // Multiply unit station
    rsStation mulStation (
        .clk (clk), .rst (rst), .flush (flush), .write (mulWrite),
        .op (op), .prs1 (prs1), .prs2 (prs2), .pDest (pDest),
        .robIdx (robIdx), .imm (imm),
        .rs1ReadyIn (rs1ReadyIn), .rs2ReadyIn (rs2ReadyIn),
        .cdbValid (cdbValid), .cdbPhysReg (cdbPhysReg), .cdbArchReg (cdbArchReg),
        .fuReady (mulFuReady), .full (mulFull), .issueValid (mulIssueValid),
        .issueOp (mulIssueOp), .issuePrs1 (mulIssuePrs1), .issuePrs2 (mulIssuePrs2),
        .issuePDest (mulIssuePDest), .issueRob (mulIssueRob), .issueImm (mulIssueImm)
    );

endmodule : reserveTop

// File: testbench/reserveTop_checker.sv
`timescale 1ns/100ps

module reserveTopChecker
import rsPkg::*;
(
    input logic     clk,
    input logic     rst,
    input logic     flush,
    input logic     addWe,
    input logic     mulWe,
    input aluOp_t   op,
    input physReg_t prs1,
    input physReg_t prs2,
    input physReg_t pDest,
    input robIdx_t  robIdx,
    input imm_t     imm,
    input logic     prs1Ready,
    input logic     prs2Ready,
    input logic     cdbValid,
    input physReg_t cdbPhysReg,
    input archReg_t cdbArchReg,
    input logic     addFuReady,
    input logic     mulFuReady,
    input logic     addFull,
    input logic     mulFull,
    input logic     addIssueValid,
    input aluOp_t   addIssueOp,
    input physReg_t addIssuePrs1,
    input physReg_t addIssuePrs2,
    input physReg_t addIssuePDest,
    input robIdx_t  addIssueRob,
    input imm_t     addIssueImm,
    input logic     mulIssueValid,
    input aluOp_t   mulIssueOp,
    input physReg_t mulIssuePrs1,
    input physReg_t mulIssuePrs2,
    input physReg_t mulIssuePDest,
    input robIdx_t  mulIssueRob,
    input imm_t     mulIssueImm
);

    int errorCount = 0;         // Read by the testbench at the end

    logic cdbLive;
    logic rdy1;                 // Operand ready after bypass
    logic rdy2;
    logic addAcc;               // Dispatch taken by add station
    logic mulAcc;
    int   addModel;             // Occupancy plus entry issued at last edge
    int   mulModel;
    int   addReal;
    int   mulReal;
    int   addPend [1 << ROB_WIDTH];     // Accepted minus issued, per ROB index
    int   mulPend [1 << ROB_WIDTH];
    logic addRobOpen;           // Issued ROB index still has a dispatch pending
    logic mulRobOpen;
    logic [57:0] fieldsNow;
    logic [57:0] fieldsD1;
    logic [57:0] fieldsD2;      // Dispatch fields two edges back
    logic [57:0] addOut;
    logic [57:0] mulOut;
    logic     waiting;          // Lone add entry waits for its rs1 tag
    logic     woken;
    physReg_t waitTag;
    robIdx_t  waitRob;

    assign cdbLive = cdbValid && (cdbArchReg != 5'd0);
    assign rdy1    = prs1Ready || (cdbLive && cdbPhysReg == prs1);
    assign rdy2    = prs2Ready || (cdbLive && cdbPhysReg == prs2);
    assign addAcc  = addWe && !addFull;
    assign mulAcc  = mulWe && !mulFull && !addAcc;     // Add wins
    assign addReal = addModel - int'(addIssueValid);
    assign mulReal = mulModel - int'(mulIssueValid);
    assign addRobOpen = addPend[addIssueRob] > 0;
    assign mulRobOpen = mulPend[mulIssueRob] > 0;
    assign fieldsNow = {op, prs1, prs2, pDest, robIdx, imm};
    assign addOut = {addIssueOp, addIssuePrs1, addIssuePrs2, addIssuePDest,
                     addIssueRob, addIssueImm};
    assign mulOut = {mulIssueOp, mulIssuePrs1, mulIssuePrs2, mulIssuePDest,
                     mulIssueRob, mulIssueImm};

    always_ff @(posedge clk) begin
        fieldsD1 <= fieldsNow;
        fieldsD2 <= fieldsD1;
        if (rst || flush) begin
            addModel <= 0;
            mulModel <= 0;
            waiting  <= 1'b0;
            woken    <= 1'b0;
            for (int r = 0; r < (1 << ROB_WIDTH); r++) begin
                addPend[r] <= 0;
                mulPend[r] <= 0;
            end
        end else begin
            addModel <= addModel + int'(addAcc) - int'(addIssueValid);
            mulModel <= mulModel + int'(mulAcc) - int'(mulIssueValid);
            // Per ROB index bookkeeping of dispatches still waiting to issue
            for (int r = 0; r < (1 << ROB_WIDTH); r++) begin
                addPend[r] <= addPend[r] + int'(addAcc && robIdx == robIdx_t'(r))
                              - int'(addIssueValid && addIssueRob == robIdx_t'(r));
                mulPend[r] <= mulPend[r] + int'(mulAcc && robIdx == robIdx_t'(r))
                              - int'(mulIssueValid && mulIssueRob == robIdx_t'(r));
            end
            if (addAcc && addReal == 0 && !rdy1 && rdy2) begin
                waiting <= 1'b1;        // Arm on a lone unready entry
                woken   <= 1'b0;
                waitTag <= prs1;
                waitRob <= robIdx;
            end else if (addAcc || addIssueValid) begin
                waiting <= 1'b0;
            end else if (waiting && cdbLive && cdbPhysReg == waitTag) begin
                woken <= 1'b1;
            end
        end
    end

    // Quiet after reset release and after flush
    assert property (@(posedge clk) ($past(rst) && !rst) || (!rst && $past(flush))
                     |-> !addFull && !mulFull && !addIssueValid && !mulIssueValid)
        else begin
            errorCount++;
            $error("Outputs not cleared after reset or flush");
        end

    // Full level follows occupancy
    assert property (@(posedge clk) disable iff (rst) addFull == (addReal == RS_NUM))
        else begin
            errorCount++;
            $error("Error addFull %h expected %h", addFull, addReal == RS_NUM);
        end
    assert property (@(posedge clk) disable iff (rst) mulFull == (mulReal == RS_NUM))
        else begin
            errorCount++;
            $error("Error mulFull %h expected %h", mulFull, mulReal == RS_NUM);
        end

    // Ready op into empty station issues one edge later
    assert property (@(posedge clk) disable iff (rst)
                     addAcc && addReal == 0 && rdy1 && rdy2 && addFuReady && !flush
                     ##1 addFuReady && !flush |=> addIssueValid && addOut == fieldsD2)
        else begin
            errorCount++;
            $error("Error addIssue %h expected %h", addOut, fieldsD2);
        end
    assert property (@(posedge clk) disable iff (rst)
                     mulAcc && mulReal == 0 && rdy1 && rdy2 && mulFuReady && !flush
                     ##1 mulFuReady && !flush |=> mulIssueValid && mulOut == fieldsD2)
        else begin
            errorCount++;
            $error("Error mulIssue %h expected %h", mulOut, fieldsD2);
        end

    // No issue before wakeup, x0 broadcasts included
    assert property (@(posedge clk) disable iff (rst) waiting && !woken |-> !addIssueValid)
        else begin
            errorCount++;
            $error("Add entry issued before its tag was broadcast");
        end
    assert property (@(posedge clk) disable iff (rst)
                     waiting && !woken && !addAcc && !flush && cdbLive && cdbPhysReg == waitTag
                     ##1 addFuReady && !flush |=> addIssueValid && addIssueRob == waitRob)
        else begin
            errorCount++;
            $error("Error addIssueRob %h expected %h", addIssueRob, waitRob);
        end

    // Unit not ready blocks issue
    assert property (@(posedge clk) disable iff (rst) !addFuReady |=> !addIssueValid)
        else begin
            errorCount++;
            $error("Add issued while its unit was not ready");
        end
    assert property (@(posedge clk) disable iff (rst) !mulFuReady |=> !mulIssueValid)
        else begin
            errorCount++;
            $error("Mul issued while its unit was not ready");
        end

    // No second issue of an entry, no issue of a dropped dispatch
    assert property (@(posedge clk) disable iff (rst) addIssueValid |-> addRobOpen)
        else begin
            errorCount++;
            $error("Error addIssueRob %h has no pending dispatch", addIssueRob);
        end
    assert property (@(posedge clk) disable iff (rst) mulIssueValid |-> mulRobOpen)
        else begin
            errorCount++;
            $error("Error mulIssueRob %h has no pending dispatch", mulIssueRob);
        end

endmodule : reserveTopChecker

bind reserveTop reserveTopChecker chk (.*);

// File: testbench/reserveTb.sv
`timescale 1ns/100ps

module reserveTb;
import rsPkg::*;

    localparam int DIRECTED_CYCLES = 58;    // Reset and directed phases
    localparam int RANDOM_CYCLES   = 300;
    localparam int DRAIN_CYCLES    = 4;
    localparam int PLANNED_CYCLES  = DIRECTED_CYCLES + RANDOM_CYCLES + DRAIN_CYCLES;
    localparam logic [31:0] SEED   = 32'he24f7997;

    logic clk = 1'b0;
    logic rst;
    logic flush;
    logic addWe, mulWe;
    aluOp_t op;
    physReg_t prs1, prs2, pDest;
    robIdx_t robIdx;
    imm_t imm;
    logic prs1Ready, prs2Ready;
    logic cdbValid;
    physReg_t cdbPhysReg;
    archReg_t cdbArchReg;
    logic addFuReady, mulFuReady;
    logic addFull, mulFull;
    logic addIssueValid, mulIssueValid;
    aluOp_t addIssueOp, mulIssueOp;
    physReg_t addIssuePrs1, addIssuePrs2, addIssuePDest;
    physReg_t mulIssuePrs1, mulIssuePrs2, mulIssuePDest;
    robIdx_t addIssueRob, mulIssueRob;
    imm_t addIssueImm, mulIssueImm;
    int errors;

    always #5 clk = ~clk;

    reserveTop reserveTop_inst (.*);

    task automatic stepCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic idle(input int n);
        repeat (n) stepCycle();
    endtask

    // One cycle of dispatch strobes, random payload
    task automatic sendOp(input logic toAdd, input logic toMul, input physReg_t s1,
                          input physReg_t s2, input logic r1, input logic r2,
                          input robIdx_t rob);
        addWe     = toAdd;
        mulWe     = toMul;
        op        = aluOp_t'($urandom);
        prs1      = s1;
        prs2      = s2;
        pDest     = physReg_t'($urandom);
        imm       = $urandom;
        prs1Ready = r1;
        prs2Ready = r2;
        robIdx    = rob;
        stepCycle();
        addWe = 1'b0;
        mulWe = 1'b0;
    endtask

    task automatic broadcast(input physReg_t tag, input archReg_t arch);
        cdbValid   = 1'b1;
        cdbPhysReg = tag;
        cdbArchReg = arch;
        stepCycle();
        cdbValid = 1'b0;
    endtask

    // Watchdog
    initial begin
        #((PLANNED_CYCLES + 200) * 10);
        $display("Timeout: the run did not finish in the expected time");
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        rst        = 1'b1;
        flush      = 1'b0;
        addWe      = 1'b0;
        mulWe      = 1'b0;
        op         = '0;
        prs1       = '0;
        prs2       = '0;
        pDest      = '0;
        robIdx     = '0;
        imm        = '0;
        prs1Ready  = 1'b0;
        prs2Ready  = 1'b0;
        cdbValid   = 1'b0;
        cdbPhysReg = '0;
        cdbArchReg = '0;
        addFuReady = 1'b1;
        mulFuReady = 1'b1;
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;
        idle(2);

        // Single dispatches, then both strobes at once
        sendOp(1'b1, 1'b0, 6'd3, 6'd4, 1'b1, 1'b1, 4'd1);
        idle(2);
        sendOp(1'b0, 1'b1, 6'd5, 6'd6, 1'b1, 1'b1, 4'd2);
        idle(2);
        sendOp(1'b1, 1'b1, 6'd7, 6'd8, 1'b1, 1'b1, 4'd3);
        idle(3);

        // Wakeup, x0 first
        sendOp(1'b1, 1'b0, 6'd10, 6'd11, 1'b0, 1'b1, 4'd4);
        idle(2);
        broadcast(6'd10, 5'd0);
        idle(2);
        broadcast(6'd10, 5'd5);
        idle(3);
        // Bypass on dispatch
        cdbValid   = 1'b1;
        cdbPhysReg = 6'd12;
        cdbArchReg = 5'd7;
        sendOp(1'b1, 1'b0, 6'd12, 6'd13, 1'b0, 1'b1, 4'd5);
        cdbValid = 1'b0;
        idle(3);

        // Fill both stations with units stalled
        addFuReady = 1'b0;
        mulFuReady = 1'b0;
        for (int i = 0; i < RS_NUM; i++) begin
            sendOp(1'b1, 1'b0, 6'd1, 6'd2, 1'b1, 1'b1, robIdx_t'(i));
        end
        for (int i = 0; i < RS_NUM; i++) begin
            sendOp(1'b0, 1'b1, 6'd1, 6'd2, 1'b1, 1'b1, robIdx_t'(i + 8));
        end
        sendOp(1'b1, 1'b0, 6'd1, 6'd2, 1'b1, 1'b1, 4'd15);     // Dropped
        idle(2);
        addFuReady = 1'b1;
        idle(2);
        mulFuReady = 1'b1;
        idle(6);

        // Flush with add station full and a mul issue due at the same edge
        addFuReady = 1'b0;
        for (int i = 0; i < RS_NUM; i++) begin
            sendOp(1'b1, 1'b0, 6'd1, 6'd2, 1'b1, 1'b1, robIdx_t'(i + 4));
        end
        sendOp(1'b0, 1'b1, 6'd1, 6'd2, 1'b1, 1'b1, 4'd9);
        flush = 1'b1;
        stepCycle();
        flush = 1'b0;
        addFuReady = 1'b1;
        idle(3);

        // Random traffic, small tag range so wakeups are frequent
        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            addWe      = ($urandom % 3) == 0;
            mulWe      = ($urandom % 3) == 0;
            op         = aluOp_t'($urandom);
            prs1       = physReg_t'($urandom % 8);
            prs2       = physReg_t'($urandom % 8);
            pDest      = physReg_t'($urandom);
            imm        = $urandom;
            prs1Ready  = ($urandom % 4) != 0;
            prs2Ready  = ($urandom % 4) != 0;
            robIdx     = robIdx_t'(c);
            cdbValid   = ($urandom % 2) != 0;
            cdbPhysReg = physReg_t'($urandom % 8);
            cdbArchReg = archReg_t'($urandom % 4);         // x0 now and then
            addFuReady = ($urandom % 4) != 0;
            mulFuReady = ($urandom % 4) != 0;
            flush      = ($urandom % 64) == 0;
            stepCycle();
        end
        addWe    = 1'b0;
        mulWe    = 1'b0;
        cdbValid = 1'b0;
        flush    = 1'b0;
        idle(DRAIN_CYCLES);

        errors = reserveTop_inst.chk.errorCount;
        $display("Run complete: %0d assertion failures", errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule : reserveTb

// File: list.f
common/rsPkg.sv
design/dispatchControl.sv
reservationStation/rsSlotPicker.sv
reservationStation/rsStation.sv
design/reserveTop.sv
testbench/reserveTop_checker.sv
testbench/reserveTb.sv
